/* rtl/axi2iob_rd_cfg.svh */
// widths are fixed for a 32 bit IOb bus and the FIFO depth must be a power of two of 2 or more
`ifndef AXI2IOB_RD_CFG_SVH
`define AXI2IOB_RD_CFG_SVH

// bus widths
`define AXI2IOB_ADDR_W 32
`define AXI2IOB_DATA_W 32

// AXI read address channel fields
`define AXI2IOB_ID_W   8
`define AXI2IOB_LEN_W  8
`define AXI2IOB_SIZE_W 3

// rresp field
`define AXI2IOB_RESP_W 2

// returned beats held between the IOb side and the R channel
`define AXI2IOB_FIFO_DEPTH 4

`endif

/* rtl/axi2iob_rd_pkg.sv */
// types for the read-only adapter and every burst is treated as INCR with rresp always OKAY
`default_nettype none

`include "axi2iob_rd_cfg.svh"

package axi2iob_rd_pkg;

  typedef logic [`AXI2IOB_ADDR_W-1:0] addr_t;
  typedef logic [`AXI2IOB_DATA_W-1:0] data_t;
  typedef logic [`AXI2IOB_ID_W-1:0]   axi_id_t;
  typedef logic [`AXI2IOB_LEN_W-1:0]  burst_len_t;
  typedef logic [`AXI2IOB_SIZE_W-1:0] burst_size_t;

  // burst sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_REQ,
    SEQ_WAIT
  } seq_state_e;

  typedef enum logic [`AXI2IOB_RESP_W-1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

endpackage

`default_nettype wire

/* rtl/ar_burst_sequencer.sv */
// one IOb read outstanding at a time and a request only goes out while the beat FIFO has room
`timescale 1ns/1ns
`default_nettype none

module ar_burst_sequencer (
  input  wire                               clk_i,
  input  wire                               arst_i,
  // AXI read address channel
  input  wire axi2iob_rd_pkg::axi_id_t      s_axi_arid_i,
  input  wire axi2iob_rd_pkg::addr_t        s_axi_araddr_i,
  input  wire axi2iob_rd_pkg::burst_len_t   s_axi_arlen_i,
  input  wire axi2iob_rd_pkg::burst_size_t  s_axi_arsize_i,
  input  wire                               s_axi_arvalid_i,
  output logic                              s_axi_arready_o,
  // IOb master, reads only
  output logic                              iob_avalid_o,
  output axi2iob_rd_pkg::addr_t             iob_addr_o,
  input  wire                               iob_ready_i,
  input  wire                               iob_rvalid_i,
  input  wire axi2iob_rd_pkg::data_t        iob_rdata_i,
  // beat FIFO write side
  input  wire                               fifo_full_i,
  output logic                              beat_push_o,
  output axi2iob_rd_pkg::data_t             beat_data_o,
  output axi2iob_rd_pkg::axi_id_t           beat_id_o,
  output logic                              beat_last_o
);

  import axi2iob_rd_pkg::*;

  seq_state_e  state_q;
  logic        arready_q;

  axi_id_t     id_q;
  addr_t       addr_q;
  burst_len_t  cnt_q;
  burst_size_t size_q;

  logic        ar_fire;
  logic        req_fire;
  logic        rsp_fire;

  assign ar_fire  = s_axi_arvalid_i & arready_q;
  assign req_fire = iob_avalid_o & iob_ready_i;
  assign rsp_fire = (state_q == SEQ_WAIT) & iob_rvalid_i;

  assign s_axi_arready_o = arready_q;

  // the FIFO only drains while a request waits, so avalid never drops once raised
  assign iob_avalid_o = (state_q == SEQ_REQ) & ~fifo_full_i;
  assign iob_addr_o   = addr_q;

  // returned word goes straight into the FIFO on the rvalid cycle
  assign beat_push_o = rsp_fire;
  assign beat_data_o = iob_rdata_i;
  assign beat_id_o   = id_q;
  assign beat_last_o = (cnt_q == '0);

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q   <= SEQ_IDLE;
      arready_q <= 1'b0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          arready_q <= ~ar_fire;
          if (ar_fire) begin
            state_q <= SEQ_REQ;
          end
        end
        SEQ_REQ: begin
          if (req_fire) begin
            state_q <= SEQ_WAIT;
          end
        end
        SEQ_WAIT: begin
          if (rsp_fire) begin
            if (beat_last_o) begin
              state_q   <= SEQ_IDLE;
              arready_q <= 1'b1;
            end else begin
              state_q <= SEQ_REQ;
            end
          end
        end
        default: begin
          state_q   <= SEQ_IDLE;
          arready_q <= 1'b0;
        end
      endcase
    end
  end

  // burst context
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_q   <= s_axi_arid_i;
      addr_q <= s_axi_araddr_i;
      cnt_q  <= s_axi_arlen_i;
      size_q <= s_axi_arsize_i;
    end else begin
      // incrementing burst, step by bytes per beat
      if (req_fire) begin
        addr_q <= addr_q + (addr_t'(1) << size_q);
      end
      if (rsp_fire) begin
        cnt_q <= cnt_q - burst_len_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rd_beat_fifo.sv */
// DEPTH must be a power of two of 2 or more and the writer must not push when full
`timescale 1ns/1ns
`default_nettype none

`include "axi2iob_rd_cfg.svh"

module rd_beat_fifo #(
  parameter int DEPTH = `AXI2IOB_FIFO_DEPTH
) (
  input  wire                           clk_i,
  input  wire                           arst_i,
  input  wire                           push_i,
  input  wire axi2iob_rd_pkg::data_t    push_data_i,
  input  wire axi2iob_rd_pkg::axi_id_t  push_id_i,
  input  wire                           push_last_i,
  input  wire                           pop_i,
  output logic                          full_o,
  output logic                          empty_o,
  output axi2iob_rd_pkg::data_t         head_data_o,
  output axi2iob_rd_pkg::axi_id_t       head_id_o,
  output logic                          head_last_o
);

  import axi2iob_rd_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);
  localparam logic [IDX_W:0] PTR_ONE = 1;

  data_t   data_mem [DEPTH];
  axi_id_t id_mem   [DEPTH];
  logic    last_mem [DEPTH];

  // extra top bit tells a full ring from an empty one
  logic [IDX_W:0]   wr_ptr_q;
  logic [IDX_W:0]   rd_ptr_q;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  assign wr_idx = wr_ptr_q[IDX_W-1:0];
  assign rd_idx = rd_ptr_q[IDX_W-1:0];

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]) && (wr_idx == rd_idx);

  assign head_data_o = data_mem[rd_idx];
  assign head_id_o   = id_mem[rd_idx];
  assign head_last_o = last_mem[rd_idx];

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + PTR_ONE;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + PTR_ONE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_mem[wr_idx] <= push_data_i;
      id_mem[wr_idx]   <= push_id_i;
      last_mem[wr_idx] <= push_last_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/r_channel_slice.sv */
// single output register on the R channel and rresp is always OKAY
`timescale 1ns/1ns
`default_nettype none

module r_channel_slice (
  input  wire                           clk_i,
  input  wire                           arst_i,
  input  wire                           fifo_empty_i,
  input  wire axi2iob_rd_pkg::data_t    head_data_i,
  input  wire axi2iob_rd_pkg::axi_id_t  head_id_i,
  input  wire                           head_last_i,
  output logic                          beat_pop_o,
  input  wire                           s_axi_rready_i,
  output logic                          s_axi_rvalid_o,
  output axi2iob_rd_pkg::axi_id_t       s_axi_rid_o,
  output axi2iob_rd_pkg::data_t         s_axi_rdata_o,
  output logic                          s_axi_rlast_o,
  output axi2iob_rd_pkg::axi_resp_e     s_axi_rresp_o
);

  import axi2iob_rd_pkg::*;

  logic rvalid_q;

  // refill when the register is free or its beat leaves this cycle
  assign beat_pop_o = ~fifo_empty_i & (~rvalid_q | s_axi_rready_i);

  assign s_axi_rvalid_o = rvalid_q;
  assign s_axi_rresp_o  = RESP_OKAY;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      rvalid_q <= 1'b0;
    end else if (beat_pop_o) begin
      rvalid_q <= 1'b1;
    end else if (s_axi_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // payload only moves on a pop, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (beat_pop_o) begin
      s_axi_rid_o   <= head_id_i;
      s_axi_rdata_o <= head_data_i;
      s_axi_rlast_o <= head_last_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/axi2iob_rd.sv */
// read-only AXI4 to IOb adapter with INCR bursts only and no error responses
`timescale 1ns/1ns
`default_nettype none

`include "axi2iob_rd_cfg.svh"

module axi2iob_rd (
  input  wire                               clk_i,
  input  wire                               arst_i,
  // AXI read address channel
  input  wire axi2iob_rd_pkg::axi_id_t      s_axi_arid_i,
  input  wire axi2iob_rd_pkg::addr_t        s_axi_araddr_i,
  input  wire axi2iob_rd_pkg::burst_len_t   s_axi_arlen_i,
  input  wire axi2iob_rd_pkg::burst_size_t  s_axi_arsize_i,
  input  wire                               s_axi_arvalid_i,
  output logic                              s_axi_arready_o,
  // AXI read data channel
  output axi2iob_rd_pkg::axi_id_t           s_axi_rid_o,
  output axi2iob_rd_pkg::data_t             s_axi_rdata_o,
  output axi2iob_rd_pkg::axi_resp_e         s_axi_rresp_o,
  output logic                              s_axi_rlast_o,
  output logic                              s_axi_rvalid_o,
  input  wire                               s_axi_rready_i,
  // IOb master
  output logic                              iob_avalid_o,
  output axi2iob_rd_pkg::addr_t             iob_addr_o,
  input  wire                               iob_ready_i,
  input  wire                               iob_rvalid_i,
  input  wire axi2iob_rd_pkg::data_t        iob_rdata_i
);

  import axi2iob_rd_pkg::*;

  logic    fifo_full;
  logic    fifo_empty;
  logic    beat_push;
  logic    beat_pop;
  data_t   beat_data;
  axi_id_t beat_id;
  logic    beat_last;
  data_t   head_data;
  axi_id_t head_id;
  logic    head_last;

  ar_burst_sequencer u_seq (
    .clk_i           (clk_i),
    .arst_i          (arst_i),
    .s_axi_arid_i    (s_axi_arid_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arlen_i   (s_axi_arlen_i),
    .s_axi_arsize_i  (s_axi_arsize_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .iob_avalid_o    (iob_avalid_o),
    .iob_addr_o      (iob_addr_o),
    .iob_ready_i     (iob_ready_i),
    .iob_rvalid_i    (iob_rvalid_i),
    .iob_rdata_i     (iob_rdata_i),
    .fifo_full_i     (fifo_full),
    .beat_push_o     (beat_push),
    .beat_data_o     (beat_data),
    .beat_id_o       (beat_id),
    .beat_last_o     (beat_last)
  );

  // decouples the IOb side from R channel stalls, beats may span two bursts
  rd_beat_fifo #(
    .DEPTH (`AXI2IOB_FIFO_DEPTH)
  ) u_fifo (
    .clk_i       (clk_i),
    .arst_i      (arst_i),
    .push_i      (beat_push),
    .push_data_i (beat_data),
    .push_id_i   (beat_id),
    .push_last_i (beat_last),
    .pop_i       (beat_pop),
    .full_o      (fifo_full),
    .empty_o     (fifo_empty),
    .head_data_o (head_data),
    .head_id_o   (head_id),
    .head_last_o (head_last)
  );

  r_channel_slice u_slice (
    .clk_i          (clk_i),
    .arst_i         (arst_i),
    .fifo_empty_i   (fifo_empty),
    .head_data_i    (head_data),
    .head_id_i      (head_id),
    .head_last_i    (head_last),
    .beat_pop_o     (beat_pop),
    .s_axi_rready_i (s_axi_rready_i),
    .s_axi_rvalid_o (s_axi_rvalid_o),
    .s_axi_rid_o    (s_axi_rid_o),
    .s_axi_rdata_o  (s_axi_rdata_o),
    .s_axi_rlast_o  (s_axi_rlast_o),
    .s_axi_rresp_o  (s_axi_rresp_o)
  );

endmodule

`default_nettype wire

/* verification/tb_axi2iob_rd.sv */
// run from the project root so the vector file path resolves, and at most 32 vectors are read
`timescale 1ns/1ns
`default_nettype none

module tb_axi2iob_rd;

  import axi2iob_rd_pkg::*;

  localparam int MAX_VEC = 32;
  localparam int VEC_W = 6;
  localparam logic [31:0] DATA_PATTERN = 32'hA5A5_0000;

  logic        clk_i;
  logic        arst_i;
  axi_id_t     s_axi_arid_i;
  addr_t       s_axi_araddr_i;
  burst_len_t  s_axi_arlen_i;
  burst_size_t s_axi_arsize_i;
  logic        s_axi_arvalid_i;
  logic        s_axi_arready_o;
  axi_id_t     s_axi_rid_o;
  data_t       s_axi_rdata_o;
  axi_resp_e   s_axi_rresp_o;
  logic        s_axi_rlast_o;
  logic        s_axi_rvalid_o;
  logic        s_axi_rready_i;
  logic        iob_avalid_o;
  addr_t       iob_addr_o;
  logic        iob_ready_i;
  logic        iob_rvalid_i;
  data_t       iob_rdata_i;

  logic [31:0] vec_mem [0:MAX_VEC*VEC_W-1];

  // expected IOb addresses and R beats with the oldest at the front
  addr_t   exp_addr_q [$];
  axi_id_t exp_id_q [$];
  data_t   exp_data_q [$];
  logic    exp_last_q [$];
  logic    exp_mode_q [$];

  int   seed = 2;
  int   err_cnt = 0;
  int   beat_cnt = 0;
  int   total_beats = 0;
  int   n_vec = 0;
  int   cycle_cnt = 0;
  int   cycle_limit = 0;
  bit   limit_ready = 1'b0;
  bit   ar_done;
  bit   ar_seen;
  int   rnd_mem;
  int   rnd_r;
  bit   mem_busy = 1'b0;
  int   mem_delay = 0;
  addr_t   mem_addr;
  bit      hold_q = 1'b0;
  axi_id_t held_id;
  data_t   held_data;
  logic    held_last;

  axi2iob_rd u_axi2iob_rd (
    .clk_i           (clk_i),
    .arst_i          (arst_i),
    .s_axi_arid_i    (s_axi_arid_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arlen_i   (s_axi_arlen_i),
    .s_axi_arsize_i  (s_axi_arsize_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rid_o     (s_axi_rid_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rlast_o   (s_axi_rlast_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .iob_avalid_o    (iob_avalid_o),
    .iob_addr_o      (iob_addr_o),
    .iob_ready_i     (iob_ready_i),
    .iob_rvalid_i    (iob_rvalid_i),
    .iob_rdata_i     (iob_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // one entry per beat with the address stepping by bytes per beat
  task automatic queue_burst(input int v);
    addr_t start;
    addr_t a;
    int    len;
    int    size;
    int    k;
    start = vec_mem[v*VEC_W+1];
    len   = int'(vec_mem[v*VEC_W+2]);
    size  = int'(vec_mem[v*VEC_W+3]);
    for (k = 0; k <= len; k++) begin
      if (k == len) begin
        a = vec_mem[v*VEC_W+5];
      end else begin
        a = start + addr_t'(k << size);
      end
      exp_addr_q.push_back(a);
      exp_id_q.push_back(vec_mem[v*VEC_W][7:0]);
      exp_data_q.push_back(a ^ DATA_PATTERN);
      exp_last_q.push_back(k == len);
      exp_mode_q.push_back(vec_mem[v*VEC_W+4][0]);
    end
  endtask

  task automatic check_r_beat();
    if (exp_id_q.size() == 0) begin
      $display("R beat with rid %h arrived when no beat was expected", s_axi_rid_o);
      err_cnt++;
    end else begin
      if (s_axi_rid_o !== exp_id_q[0]) begin
        $display("error %0t: rid %h, expected %h", $time, s_axi_rid_o, exp_id_q[0]);
        err_cnt++;
      end
      if (s_axi_rdata_o !== exp_data_q[0]) begin
        $display("error %0t: rdata %h, expected %h", $time, s_axi_rdata_o, exp_data_q[0]);
        err_cnt++;
      end
      if (s_axi_rlast_o !== exp_last_q[0]) begin
        $display("error %0t: rlast %b, expected %b", $time, s_axi_rlast_o, exp_last_q[0]);
        err_cnt++;
      end
      if (s_axi_rresp_o !== RESP_OKAY) begin
        $display("error %0t: rresp %b, expected OKAY", $time, s_axi_rresp_o);
        err_cnt++;
      end
      void'(exp_id_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(exp_last_q.pop_front());
      void'(exp_mode_q.pop_front());
      beat_cnt++;
    end
  endtask

  // IOb slave that answers each read after a random delay
  always @(posedge clk_i) begin
    iob_rvalid_i <= 1'b0;
    if (mem_busy) begin
      if (mem_delay == 0) begin
        iob_rvalid_i <= 1'b1;
        iob_rdata_i  <= mem_addr ^ DATA_PATTERN;
        mem_busy = 1'b0;
      end else begin
        mem_delay = mem_delay - 1;
      end
    end
    if (iob_avalid_o && iob_ready_i) begin
      if (mem_busy) begin
        $display("a second IOb read was issued while one was still outstanding");
        err_cnt++;
      end
      if (exp_addr_q.size() == 0) begin
        $display("IOb read at %h arrived with no burst expecting it", iob_addr_o);
        err_cnt++;
      end else begin
        if (iob_addr_o !== exp_addr_q[0]) begin
          $display("error %0t: iob_addr %h, expected %h", $time, iob_addr_o, exp_addr_q[0]);
          err_cnt++;
        end
        void'(exp_addr_q.pop_front());
      end
      mem_addr  = iob_addr_o;
      mem_busy  = 1'b1;
      rnd_mem   = $random(seed);
      mem_delay = rnd_mem & 3;
    end
    rnd_mem = $random(seed);
    iob_ready_i <= rnd_mem[0];
  end

  // R channel checker and rready driver
  always @(posedge clk_i) begin
    if (hold_q) begin
      if (!s_axi_rvalid_o || s_axi_rid_o !== held_id || s_axi_rdata_o !== held_data ||
          s_axi_rlast_o !== held_last) begin
        $display("error %0t: R channel changed while stalled by rready", $time);
        err_cnt++;
      end
    end
    hold_q    = s_axi_rvalid_o && !s_axi_rready_i;
    held_id   = s_axi_rid_o;
    held_data = s_axi_rdata_o;
    held_last = s_axi_rlast_o;
    if (s_axi_rvalid_o && s_axi_rready_i) begin
      check_r_beat();
    end
    if (exp_mode_q.size() != 0 && exp_mode_q[0]) begin
      // rready high about one cycle in eight so the beat FIFO fills and stalls the IOb side
      rnd_r = $random(seed);
      s_axi_rready_i <= (rnd_r[2:0] == 3'd0);
    end else begin
      s_axi_rready_i <= 1'b1;
    end
  end

  initial begin
    wait (limit_ready);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, %0d of %0d beats received", cycle_cnt, beat_cnt,
             total_beats);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    arst_i          = 1'b1;
    s_axi_arid_i    = '0;
    s_axi_araddr_i  = '0;
    s_axi_arlen_i   = '0;
    s_axi_arsize_i  = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b0;
    iob_ready_i     = 1'b0;
    iob_rvalid_i    = 1'b0;
    iob_rdata_i     = '0;
    for (int i = 0; i < MAX_VEC*VEC_W; i++) begin
      vec_mem[i] = '1;
    end
    $readmemh("verification/axi2iob_rd_vectors.txt", vec_mem);
    while (n_vec < MAX_VEC && vec_mem[n_vec*VEC_W] !== '1) begin
      total_beats = total_beats + int'(vec_mem[n_vec*VEC_W+2]) + 1;
      n_vec++;
    end
    if (n_vec == 0) begin
      $display("no vectors were read from the vector file");
      err_cnt++;
    end
    cycle_limit = 64 * total_beats + 200;
    limit_ready = 1'b1;

    repeat (2) @(posedge clk_i);
    arst_i <= 1'b0;
    ar_seen = 1'b0;
    for (int i = 0; i < 3 && !ar_seen; i++) begin
      if (s_axi_rvalid_o !== 1'b0 || iob_avalid_o !== 1'b0) begin
        $display("error %0t: rvalid or avalid high after reset", $time);
        err_cnt++;
      end
      @(posedge clk_i);
      ar_seen = (s_axi_arready_o === 1'b1);
    end
    if (!ar_seen) begin
      $display("error %0t: arready not high within two cycles of reset release", $time);
      err_cnt++;
    end

    // bursts go out back to back as soon as arready allows
    for (int v = 0; v < n_vec; v++) begin
      s_axi_arid_i    <= vec_mem[v*VEC_W][7:0];
      s_axi_araddr_i  <= vec_mem[v*VEC_W+1];
      s_axi_arlen_i   <= vec_mem[v*VEC_W+2][7:0];
      s_axi_arsize_i  <= vec_mem[v*VEC_W+3][2:0];
      s_axi_arvalid_i <= 1'b1;
      ar_done = 1'b0;
      while (!ar_done) begin
        @(posedge clk_i);
        if (s_axi_arready_o && s_axi_arvalid_i) begin
          ar_done = 1'b1;
          queue_burst(v);
        end
      end
    end
    s_axi_arvalid_i <= 1'b0;

    while (exp_id_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (8) @(posedge clk_i);
    if (exp_addr_q.size() != 0) begin
      $display("%0d expected IOb reads were never issued", exp_addr_q.size());
      err_cnt++;
    end
    $display("bursts %0d, beats %0d of %0d, errors %0d", n_vec, beat_cnt, total_beats, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/axi2iob_rd_vectors.txt */
// id start_addr arlen arsize rready_mode last_addr, all hex
// rready_mode 0 keeps rready high, 1 drives it at random
01 00001000 00 2 0 00001000
02 00002004 00 2 1 00002004
03 00003000 03 2 0 0000300c
04 00004001 07 0 0 00004008
05 00005008 05 3 0 00005030
06 00006000 0f 2 1 0000603c
07 00007010 03 0 1 00007013
08 00008000 07 3 1 00008038
10 00009000 01 2 0 00009004
11 0000a000 01 2 0 0000a004
12 0000b000 02 2 1 0000b008
13 0000c100 00 0 1 0000c100
14 0000d000 0a 2 1 0000d028
15 0000e0f0 04 3 0 0000e110
16 0000f002 05 0 1 0000f007
20 00010000 03 2 1 0001000c
21 00010100 03 2 1 0001010c
22 00011000 1f 2 1 0001107c
23 00012000 00 3 0 00012000
24 00013ffc 02 2 1 00014004
25 00014000 06 3 1 00014030
26 00015000 02 0 0 00015002
27 00016000 07 2 1 0001601c
a5 00017000 03 2 0 0001700c

/* files.f */
+incdir+rtl
rtl/axi2iob_rd_pkg.sv
rtl/ar_burst_sequencer.sv
rtl/rd_beat_fifo.sv
rtl/r_channel_slice.sv
rtl/axi2iob_rd.sv
verification/tb_axi2iob_rd.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_axi2iob_rd -f files.f -o tb_axi2iob_rd

out=$(./obj_dir/tb_axi2iob_rd)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TB PASSED"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
